/* src/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    typedef logic [5:0]  op_t;
    typedef logic [5:0]  func_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // primary opcodes
    localparam op_t OP_SPECIAL = 6'b000000;
    localparam op_t OP_REGIMM  = 6'b000001;
    localparam op_t OP_J       = 6'b000010;
    localparam op_t OP_JAL     = 6'b000011;
    localparam op_t OP_BEQ     = 6'b000100;
    localparam op_t OP_BNE     = 6'b000101;
    localparam op_t OP_BLEZ    = 6'b000110;
    localparam op_t OP_BGTZ    = 6'b000111;
    localparam op_t OP_ADDI    = 6'b001000;
    localparam op_t OP_ADDIU   = 6'b001001;
    localparam op_t OP_SLTI    = 6'b001010;
    localparam op_t OP_SLTIU   = 6'b001011;
    localparam op_t OP_ANDI    = 6'b001100;
    localparam op_t OP_ORI     = 6'b001101;
    localparam op_t OP_XORI    = 6'b001110;
    localparam op_t OP_LUI     = 6'b001111;
    localparam op_t OP_COP0    = 6'b010000;
    localparam op_t OP_LB      = 6'b100000;
    localparam op_t OP_LH      = 6'b100001;
    localparam op_t OP_LW      = 6'b100011;
    localparam op_t OP_LBU     = 6'b100100;
    localparam op_t OP_LHU     = 6'b100101;
    localparam op_t OP_SB      = 6'b101000;
    localparam op_t OP_SH      = 6'b101001;
    localparam op_t OP_SW      = 6'b101011;

    // function field under SPECIAL
    localparam func_t F_SLL     = 6'b000000;
    localparam func_t F_SRL     = 6'b000010;
    localparam func_t F_SRA     = 6'b000011;
    localparam func_t F_SLLV    = 6'b000100;
    localparam func_t F_SRLV    = 6'b000110;
    localparam func_t F_SRAV    = 6'b000111;
    localparam func_t F_JR      = 6'b001000;
    localparam func_t F_JALR    = 6'b001001;
    localparam func_t F_SYSCALL = 6'b001100;
    localparam func_t F_BREAK   = 6'b001101;
    localparam func_t F_MFHI    = 6'b010000;
    localparam func_t F_MTHI    = 6'b010001;
    localparam func_t F_MFLO    = 6'b010010;
    localparam func_t F_MTLO    = 6'b010011;
    localparam func_t F_MULT    = 6'b011000;
    localparam func_t F_MULTU   = 6'b011001;
    localparam func_t F_DIV     = 6'b011010;
    localparam func_t F_DIVU    = 6'b011011;
    localparam func_t F_ADD     = 6'b100000;
    localparam func_t F_ADDU    = 6'b100001;
    localparam func_t F_SUB     = 6'b100010;
    localparam func_t F_SUBU    = 6'b100011;
    localparam func_t F_AND     = 6'b100100;
    localparam func_t F_OR      = 6'b100101;
    localparam func_t F_XOR     = 6'b100110;
    localparam func_t F_NOR     = 6'b100111;
    localparam func_t F_SLT     = 6'b101010;
    localparam func_t F_SLTU    = 6'b101011;

    // rt field under REGIMM
    localparam reg_addr_t B_BLTZ   = 5'b00000;
    localparam reg_addr_t B_BGEZ   = 5'b00001;
    localparam reg_addr_t B_BLTZAL = 5'b10000;
    localparam reg_addr_t B_BGEZAL = 5'b10001;

    // rs field under COP0
    localparam reg_addr_t C_MFC0 = 5'b00000;
    localparam reg_addr_t C_MTC0 = 5'b00100;
    localparam reg_addr_t C_ERET = 5'b10000;

    typedef enum logic [6:0] {
        ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, NOR, OR, XOR,
        SLLV, SLL, SRAV, SRA, SRLV, SRL, LUI,
        BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ,
        J, JAL, JR, JALR,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        ERET, MFC0, MTC0,
        DIV, DIVU, MULT, MULTU, MFHI, MFLO, MTHI, MTLO,
        BREAK, SYSCALL, RESERVED
    } decoded_op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRA, ALU_SRL
    } alufunc_t;

endpackage

`default_nettype wire

/* src/mips_pipe_pkg.sv */
`default_nettype none

package mips_pipe_pkg;

    import mips_isa_pkg::*;

    // instruction word as seen by decode, R-type field layout
    typedef struct packed {
        op_t       op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        func_t     funct;
    } fetch_t;

    typedef enum logic [1:0] {SHSRC_FIELD, SHSRC_RS, SHSRC_16} shamt_src_t;
    typedef enum logic {BSRC_RT, BSRC_IMM} b_src_t;

    typedef struct packed {
        decoded_op_t op;
        alufunc_t    alufunc;
        word_t       rs_val;
        word_t       rt_val;
        word_t       imm;
        shamt_src_t  shamt_src;
        b_src_t      b_src;
        reg_addr_t   dst;
        logic        we;
    } exec_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef struct packed {
        decoded_op_t op;
        word_t       result;
        logic        we;
        reg_addr_t   dst;
        logic        taken;
        logic        reserved;
    } retire_t;

endpackage

`default_nettype wire

/* src/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload holds through idle cycles
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire reg_addr_t rs_addr,
    input  wire reg_addr_t rt_addr,
    output word_t          rs_data,
    output word_t          rt_data,
    input  wire wb_t       wb
);

    word_t regs [32];
    logic  wr_hit;

    // register zero never takes a write
    assign wr_hit = wb.en && (wb.addr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // same-cycle write bypass gives sequential semantics
    always_comb begin
        if (wr_hit && (wb.addr == rs_addr)) begin
            rs_data = wb.data;
        end else begin
            rs_data = regs[rs_addr];
        end
    end

    always_comb begin
        if (wr_hit && (wb.addr == rt_addr)) begin
            rt_data = wb.data;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

endmodule

`default_nettype wire

/* src/alu_ctl_dec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_ctl_dec
    import mips_isa_pkg::*;
(
    input  wire decoded_op_t op,
    output alufunc_t         alufunc
);

    always_comb begin
        case (op)
            ADD:     alufunc = ALU_ADD;
            ADDU:    alufunc = ALU_ADDU;
            SUB:     alufunc = ALU_SUB;
            SUBU:    alufunc = ALU_SUBU;
            SLT:     alufunc = ALU_SLT;
            SLTU:    alufunc = ALU_SLTU;
            AND:     alufunc = ALU_AND;
            NOR:     alufunc = ALU_NOR;
            OR:      alufunc = ALU_OR;
            XOR:     alufunc = ALU_XOR;
            // variable shifts share the plain shifter
            SLLV:    alufunc = ALU_SLL;
            SLL:     alufunc = ALU_SLL;
            SRAV:    alufunc = ALU_SRA;
            SRA:     alufunc = ALU_SRA;
            SRLV:    alufunc = ALU_SRL;
            SRL:     alufunc = ALU_SRL;
            // immediate shifted up by 16
            LUI:     alufunc = ALU_SLL;
            // loads and stores form their address here
            default: alufunc = ALU_ADDU;
        endcase
    end

endmodule

`default_nettype wire

/* src/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  wire logic   valid,
    input  wire fetch_t instr,
    output reg_addr_t   rs_addr,
    output reg_addr_t   rt_addr,
    input  wire word_t  rs_data,
    input  wire word_t  rt_data,
    output exec_t       bundle
);

    decoded_op_t dop;
    alufunc_t    alufunc;
    logic [15:0] imm16;
    logic        zero_ext;
    logic        b_imm;
    logic        writes;
    shamt_src_t  shamt_src;

    assign rs_addr = instr.rs;
    assign rt_addr = instr.rt;
    assign imm16   = {instr.rd, instr.shamt, instr.funct};

    always_comb begin
        dop = RESERVED;
        case (instr.op)
            OP_ADDI:  dop = ADD;
            OP_ADDIU: dop = ADDU;
            OP_SLTI:  dop = SLT;
            OP_SLTIU: dop = SLTU;
            OP_ANDI:  dop = AND;
            OP_ORI:   dop = OR;
            OP_XORI:  dop = XOR;
            OP_LUI:   dop = LUI;
            OP_BEQ:   dop = BEQ;
            OP_BNE:   dop = BNE;
            OP_BGTZ:  dop = BGTZ;
            OP_BLEZ:  dop = BLEZ;
            OP_J:     dop = J;
            OP_JAL:   dop = JAL;
            OP_LB:    dop = LB;
            OP_LBU:   dop = LBU;
            OP_LH:    dop = LH;
            OP_LHU:   dop = LHU;
            OP_LW:    dop = LW;
            OP_SB:    dop = SB;
            OP_SH:    dop = SH;
            OP_SW:    dop = SW;
            OP_REGIMM: begin
                case (instr.rt)
                    B_BLTZ:   dop = BLTZ;
                    B_BGEZ:   dop = BGEZ;
                    B_BLTZAL: dop = BLTZAL;
                    B_BGEZAL: dop = BGEZAL;
                    default:  dop = RESERVED;
                endcase
            end
            OP_COP0: begin
                case (instr.rs)
                    C_MFC0:  dop = MFC0;
                    C_MTC0:  dop = MTC0;
                    C_ERET:  dop = ERET;
                    default: dop = RESERVED;
                endcase
            end
            OP_SPECIAL: begin
                case (instr.funct)
                    F_ADD:     dop = ADD;
                    F_ADDU:    dop = ADDU;
                    F_SUB:     dop = SUB;
                    F_SUBU:    dop = SUBU;
                    F_SLT:     dop = SLT;
                    F_SLTU:    dop = SLTU;
                    F_AND:     dop = AND;
                    F_NOR:     dop = NOR;
                    F_OR:      dop = OR;
                    F_XOR:     dop = XOR;
                    F_SLL:     dop = SLL;
                    F_SLLV:    dop = SLLV;
                    F_SRA:     dop = SRA;
                    F_SRAV:    dop = SRAV;
                    F_SRL:     dop = SRL;
                    F_SRLV:    dop = SRLV;
                    F_JR:      dop = JR;
                    F_JALR:    dop = JALR;
                    F_MULT:    dop = MULT;
                    F_MULTU:   dop = MULTU;
                    F_DIV:     dop = DIV;
                    F_DIVU:    dop = DIVU;
                    F_MFHI:    dop = MFHI;
                    F_MFLO:    dop = MFLO;
                    F_MTHI:    dop = MTHI;
                    F_MTLO:    dop = MTLO;
                    F_BREAK:   dop = BREAK;
                    F_SYSCALL: dop = SYSCALL;
                    default:   dop = RESERVED;
                endcase
            end
            default: dop = RESERVED;
        endcase
    end

    alu_ctl_dec alu_ctl_dec_i (
        .op      (dop),
        .alufunc (alufunc)
    );

    // logical immediates and LUI take the zero-extended form
    assign zero_ext = instr.op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    // ALU immediates plus loads and stores use the immediate as operand b
    assign b_imm = (instr.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                     OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
                   || instr.op[5];

    assign writes = dop inside {ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, NOR, OR, XOR,
                                SLLV, SLL, SRAV, SRA, SRLV, SRL, LUI};

    always_comb begin
        case (dop)
            SLLV, SRLV, SRAV: shamt_src = SHSRC_RS;
            LUI:              shamt_src = SHSRC_16;
            default:          shamt_src = SHSRC_FIELD;
        endcase
    end

    always_comb begin
        bundle.op        = dop;
        bundle.alufunc   = alufunc;
        bundle.rs_val    = rs_data;
        bundle.rt_val    = rt_data;
        bundle.imm       = zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
        bundle.shamt_src = shamt_src;
        bundle.b_src     = b_imm ? BSRC_IMM : BSRC_RT;
        // rd for R-type, rt otherwise
        bundle.dst       = (instr.op == OP_SPECIAL) ? instr.rd : instr.rt;
        bundle.we        = valid && writes;
    end

endmodule

`default_nettype wire

/* src/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  wire logic  valid,
    input  wire exec_t bundle,
    output wb_t        wb,
    output logic       out_valid,
    output retire_t    retire
);

    word_t      a;
    word_t      b;
    logic [4:0] shamt;
    word_t      alu_out;
    logic       is_mem;
    logic       taken;

    assign a = bundle.rs_val;
    assign b = (bundle.b_src == BSRC_IMM) ? bundle.imm : bundle.rt_val;

    always_comb begin
        case (bundle.shamt_src)
            SHSRC_RS: shamt = bundle.rs_val[4:0];
            SHSRC_16: shamt = 5'd16;
            default:  shamt = bundle.imm[10:6];
        endcase
    end

    // shifts act on operand b, no overflow traps
    always_comb begin
        case (bundle.alufunc)
            ALU_ADD, ALU_ADDU: alu_out = a + b;
            ALU_SUB, ALU_SUBU: alu_out = a - b;
            ALU_SLT:  alu_out = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: alu_out = {31'd0, a < b};
            ALU_AND:  alu_out = a & b;
            ALU_NOR:  alu_out = ~(a | b);
            ALU_OR:   alu_out = a | b;
            ALU_XOR:  alu_out = a ^ b;
            ALU_SLL:  alu_out = b << shamt;
            ALU_SRA:  alu_out = word_t'($signed(b) >>> shamt);
            ALU_SRL:  alu_out = b >> shamt;
            default:  alu_out = '0;
        endcase
    end

    assign is_mem = bundle.op inside {LB, LBU, LH, LHU, LW, SB, SH, SW};

    always_comb begin
        case (bundle.op)
            BEQ:             taken = (bundle.rs_val == bundle.rt_val);
            BNE:             taken = (bundle.rs_val != bundle.rt_val);
            BGEZ, BGEZAL:    taken = !bundle.rs_val[31];
            BLTZ, BLTZAL:    taken = bundle.rs_val[31];
            BGTZ:            taken = !bundle.rs_val[31] && (bundle.rs_val != '0);
            BLEZ:            taken = bundle.rs_val[31] || (bundle.rs_val == '0);
            J, JAL, JR, JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign wb.en   = valid && bundle.we;
    assign wb.addr = bundle.dst;
    assign wb.data = alu_out;

    assign out_valid       = valid;
    assign retire.op       = bundle.op;
    assign retire.result   = (bundle.we || is_mem) ? alu_out : '0;
    assign retire.we       = bundle.we;
    assign retire.dst      = bundle.dst;
    assign retire.taken    = taken;
    assign retire.reserved = (bundle.op == RESERVED);

endmodule

`default_nettype wire

/* src/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   in_valid,
    input  wire fetch_t instr,
    output logic        out_valid,
    output retire_t     retire
);

    logic      d_valid;
    fetch_t    d_data;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    exec_t     d_bundle;
    logic      e_valid;
    exec_t     e_data;
    wb_t       wb;

    // decode stage register
    pipe_reg #(.payload_t(fetch_t)) d_reg_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (instr),
        .out_valid (d_valid),
        .out_data  (d_data)
    );

    decode decode_i (
        .valid   (d_valid),
        .instr   (d_data),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .bundle  (d_bundle)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    // execute stage register
    pipe_reg #(.payload_t(exec_t)) e_reg_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (d_valid),
        .in_data   (d_bundle),
        .out_valid (e_valid),
        .out_data  (e_data)
    );

    execute execute_i (
        .valid     (e_valid),
        .bundle    (e_data),
        .wb        (wb),
        .out_valid (out_valid),
        .retire    (retire)
    );

endmodule

`default_nettype wire

/* tb/mips_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core_assert
    import mips_isa_pkg::*;
(
    input wire logic      clk,
    input wire logic      arst_n,
    input wire logic      in_valid,
    input wire logic      out_valid,
    input wire reg_addr_t rs_addr,
    input wire reg_addr_t rt_addr,
    input wire word_t     rs_data,
    input wire word_t     rt_data
);

    // both stages are empty for two edges after reset release
    quiet_after_reset: assert property (@(posedge clk)
        (!$past(arst_n, 1) || !$past(arst_n, 2)) |-> !out_valid)
        else $error("out_valid high within two cycles of reset release");

    two_cycle_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    // register zero reads zero whatever was written to it
    zero_reg_rs: assert property (@(posedge clk) (rs_addr == '0) |-> (rs_data == '0))
        else $error("rs read of register zero is nonzero");

    zero_reg_rt: assert property (@(posedge clk) (rt_addr == '0) |-> (rt_data == '0))
        else $error("rt read of register zero is nonzero");

endmodule

bind mips_core mips_core_assert mips_core_assert_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .rs_addr   (rs_addr),
    .rt_addr   (rt_addr),
    .rs_data   (rs_data),
    .rt_data   (rt_data)
);

`default_nettype wire

/* tb/mips_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb
    import mips_isa_pkg::*, mips_pipe_pkg::*;
();

    localparam int N_INSTR    = 300;
    localparam int MAX_CYCLES = N_INSTR * 2 + 50;

    // which instruction field carries the sub-code
    localparam logic [1:0] SEL_NONE = 2'd0;
    localparam logic [1:0] SEL_FN   = 2'd1;
    localparam logic [1:0] SEL_RT   = 2'd2;
    localparam logic [1:0] SEL_RS   = 2'd3;

    typedef struct packed {
        op_t         opc;
        logic [1:0]  sel;
        logic [5:0]  code;
        decoded_op_t op;
    } enc_t;

    // R-type 0..15, immediates 16..23, branches 24..35, memory 36..43, system 44..56
    localparam enc_t ENC [57] = '{
        '{OP_SPECIAL, SEL_FN, F_ADD, ADD},    '{OP_SPECIAL, SEL_FN, F_ADDU, ADDU},
        '{OP_SPECIAL, SEL_FN, F_SUB, SUB},    '{OP_SPECIAL, SEL_FN, F_SUBU, SUBU},
        '{OP_SPECIAL, SEL_FN, F_SLT, SLT},    '{OP_SPECIAL, SEL_FN, F_SLTU, SLTU},
        '{OP_SPECIAL, SEL_FN, F_AND, AND},    '{OP_SPECIAL, SEL_FN, F_NOR, NOR},
        '{OP_SPECIAL, SEL_FN, F_OR, OR},      '{OP_SPECIAL, SEL_FN, F_XOR, XOR},
        '{OP_SPECIAL, SEL_FN, F_SLL, SLL},    '{OP_SPECIAL, SEL_FN, F_SRL, SRL},
        '{OP_SPECIAL, SEL_FN, F_SRA, SRA},    '{OP_SPECIAL, SEL_FN, F_SLLV, SLLV},
        '{OP_SPECIAL, SEL_FN, F_SRLV, SRLV},  '{OP_SPECIAL, SEL_FN, F_SRAV, SRAV},
        '{OP_ADDI, SEL_NONE, 6'd0, ADD},      '{OP_ADDIU, SEL_NONE, 6'd0, ADDU},
        '{OP_SLTI, SEL_NONE, 6'd0, SLT},      '{OP_SLTIU, SEL_NONE, 6'd0, SLTU},
        '{OP_ANDI, SEL_NONE, 6'd0, AND},      '{OP_ORI, SEL_NONE, 6'd0, OR},
        '{OP_XORI, SEL_NONE, 6'd0, XOR},      '{OP_LUI, SEL_NONE, 6'd0, LUI},
        '{OP_BEQ, SEL_NONE, 6'd0, BEQ},       '{OP_BNE, SEL_NONE, 6'd0, BNE},
        '{OP_BLEZ, SEL_NONE, 6'd0, BLEZ},     '{OP_BGTZ, SEL_NONE, 6'd0, BGTZ},
        '{OP_REGIMM, SEL_RT, {1'b0, B_BLTZ}, BLTZ},
        '{OP_REGIMM, SEL_RT, {1'b0, B_BGEZ}, BGEZ},
        '{OP_REGIMM, SEL_RT, {1'b0, B_BLTZAL}, BLTZAL},
        '{OP_REGIMM, SEL_RT, {1'b0, B_BGEZAL}, BGEZAL},
        '{OP_J, SEL_NONE, 6'd0, J},           '{OP_JAL, SEL_NONE, 6'd0, JAL},
        '{OP_SPECIAL, SEL_FN, F_JR, JR},      '{OP_SPECIAL, SEL_FN, F_JALR, JALR},
        '{OP_LB, SEL_NONE, 6'd0, LB},         '{OP_LBU, SEL_NONE, 6'd0, LBU},
        '{OP_LH, SEL_NONE, 6'd0, LH},         '{OP_LHU, SEL_NONE, 6'd0, LHU},
        '{OP_LW, SEL_NONE, 6'd0, LW},         '{OP_SB, SEL_NONE, 6'd0, SB},
        '{OP_SH, SEL_NONE, 6'd0, SH},         '{OP_SW, SEL_NONE, 6'd0, SW},
        '{OP_SPECIAL, SEL_FN, F_MFHI, MFHI},  '{OP_SPECIAL, SEL_FN, F_MFLO, MFLO},
        '{OP_SPECIAL, SEL_FN, F_MTHI, MTHI},  '{OP_SPECIAL, SEL_FN, F_MTLO, MTLO},
        '{OP_SPECIAL, SEL_FN, F_MULT, MULT},  '{OP_SPECIAL, SEL_FN, F_MULTU, MULTU},
        '{OP_SPECIAL, SEL_FN, F_DIV, DIV},    '{OP_SPECIAL, SEL_FN, F_DIVU, DIVU},
        '{OP_SPECIAL, SEL_FN, F_BREAK, BREAK},
        '{OP_SPECIAL, SEL_FN, F_SYSCALL, SYSCALL},
        '{OP_COP0, SEL_RS, {1'b0, C_MFC0}, MFC0},
        '{OP_COP0, SEL_RS, {1'b0, C_MTC0}, MTC0},
        '{OP_COP0, SEL_RS, {1'b0, C_ERET}, ERET}
    };

    logic       clk = 1'b0;
    logic       arst_n;
    logic       in_valid;
    fetch_t     instr;
    logic       out_valid;
    retire_t    retire;

    integer     seed;
    int         cycles;
    int         n_err;
    int         n_retired;
    logic [1:0] valid_hist;
    word_t      regs [32];
    retire_t    exp_q [$];
    string      name_q [$];

    mips_core dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .out_valid (out_valid),
        .retire    (retire)
    );

    always #50 clk = ~clk;

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // weighted pick of one instruction and the op it should decode to
    task automatic pick_instr(output fetch_t w, output decoded_op_t eop, output string name);
        int   cls;
        int   idx;
        enc_t e;
        w = fetch_t'($random(seed));
        // narrow register window so results feed later instructions
        w.rs[4:3] = 2'b00;
        w.rt[4:3] = 2'b00;
        w.rd[4:3] = 2'b00;
        cls = rnd(100);
        idx = -1;
        name = "reserved";
        if (cls < 30) begin
            idx = rnd(16);
            name = "alu_r";
        end else if (cls < 55) begin
            idx = 16 + rnd(8);
            name = "alu_imm";
        end else if (cls < 70) begin
            idx = 24 + rnd(12);
            name = "branch";
        end else if (cls < 82) begin
            idx = 36 + rnd(8);
            name = "mem";
        end else if (cls < 92) begin
            idx = 44 + rnd(13);
            name = "system";
        end
        if (idx < 0) begin
            eop = RESERVED;
            // upper opcode quarter and SPECIAL functions 111xxx are unassigned
            if (rnd(2) == 0) begin
                w.op[5:4] = 2'b11;
            end else begin
                w.op = OP_SPECIAL;
                w.funct[5:3] = 3'b111;
            end
        end else begin
            e = ENC[idx];
            w.op = e.opc;
            case (e.sel)
                SEL_FN:  w.funct = e.code;
                SEL_RT:  w.rt = e.code[4:0];
                SEL_RS:  w.rs = e.code[4:0];
                default: ;
            endcase
            eop = e.op;
        end
    endtask

    // sequential reference, one instruction at a time in program order
    task automatic run_model(input fetch_t w, input decoded_op_t eop, output retire_t r);
        word_t      a;
        word_t      bt;
        word_t      sx;
        word_t      bs;
        word_t      bz;
        word_t      res;
        logic [4:0] s;
        logic       writes;
        logic       mem;
        a   = regs[w.rs];
        bt  = regs[w.rt];
        sx  = {{16{w.rd[4]}}, w.rd, w.shamt, w.funct};
        bs  = (w.op == OP_SPECIAL) ? bt : sx;
        bz  = (w.op == OP_SPECIAL) ? bt : {16'h0000, w.rd, w.shamt, w.funct};
        s   = (eop inside {SLLV, SRLV, SRAV}) ? a[4:0] : w.shamt;
        res = '0;
        r   = '0;
        case (eop)
            ADD, ADDU:        res = a + bs;
            SUB, SUBU:        res = a - bt;
            SLT:              res = ($signed(a) < $signed(bs)) ? 32'd1 : 32'd0;
            SLTU:             res = (a < bs) ? 32'd1 : 32'd0;
            AND:              res = a & bz;
            OR:               res = a | bz;
            XOR:              res = a ^ bz;
            NOR:              res = ~(a | bt);
            SLL, SLLV:        res = bt << s;
            SRL, SRLV:        res = bt >> s;
            SRA, SRAV:        res = bt[31] ? ~(~bt >> s) : (bt >> s);
            LUI:              res = {w.rd, w.shamt, w.funct, 16'h0000};
            LB, LBU, LH, LHU, LW, SB, SH, SW: res = a + sx;
            BEQ:              r.taken = (a == bt);
            BNE:              r.taken = (a != bt);
            BGEZ, BGEZAL:     r.taken = ($signed(a) >= 0);
            BLTZ, BLTZAL:     r.taken = ($signed(a) < 0);
            BGTZ:             r.taken = ($signed(a) > 0);
            BLEZ:             r.taken = ($signed(a) <= 0);
            J, JAL, JR, JALR: r.taken = 1'b1;
            default:          ;
        endcase
        writes = eop inside {ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, NOR, OR, XOR,
                             SLLV, SLL, SRAV, SRA, SRLV, SRL, LUI};
        mem = eop inside {LB, LBU, LH, LHU, LW, SB, SH, SW};
        r.op       = eop;
        r.result   = (writes || mem) ? res : '0;
        r.we       = writes;
        r.dst      = (w.op == OP_SPECIAL) ? w.rd : w.rt;
        r.reserved = (eop == RESERVED);
        if (writes && (r.dst != 5'd0)) begin
            regs[r.dst] = res;
        end
    endtask

    task automatic check_field(input string test, input string field,
                               input word_t exp, input word_t got);
        assert (got == exp) else begin
            n_err++;
            $display("error %s #%0d %s: expected %h actual %h",
                     test, n_retired, field, exp, got);
        end
    endtask

    task automatic compare_retire(input retire_t exp, input string test, input retire_t got);
        check_field(test, "op", word_t'(exp.op), word_t'(got.op));
        check_field(test, "result", exp.result, got.result);
        check_field(test, "we", word_t'(exp.we), word_t'(got.we));
        check_field(test, "dst", word_t'(exp.dst), word_t'(got.dst));
        check_field(test, "taken", word_t'(exp.taken), word_t'(got.taken));
        check_field(test, "reserved", word_t'(exp.reserved), word_t'(got.reserved));
    endtask

    // in_valid history, out_valid must mirror the older bit
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_hist <= 2'b00;
        end else begin
            valid_hist <= {valid_hist[0], in_valid};
        end
    end

    always @(negedge clk) begin
        assert (out_valid == valid_hist[1]) else begin
            n_err++;
            $display("error latency: out_valid expected %0b actual %0b",
                     valid_hist[1], out_valid);
        end
        if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                n_err++;
                $display("out_valid raised with no instruction outstanding");
            end
            if (exp_q.size() != 0) begin
                compare_retire(exp_q.pop_front(), name_q.pop_front(), retire);
                n_retired++;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d results still missing",
                     cycles, exp_q.size());
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        fetch_t      w;
        decoded_op_t eop;
        string       name;
        retire_t     r;
        int          issued;
        seed      = 9274;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        instr     = '0;
        cycles    = 0;
        n_err     = 0;
        n_retired = 0;
        issued    = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        while (issued < N_INSTR) begin
            @(posedge clk);
            #1;
            if (rnd(4) != 0) begin
                pick_instr(w, eop, name);
                run_model(w, eop, r);
                exp_q.push_back(r);
                name_q.push_back(name);
                instr    = w;
                in_valid = 1'b1;
                issued++;
            end else begin
                // idle cycle with junk on the instruction bus
                in_valid = 1'b0;
                instr    = fetch_t'($random(seed));
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d, retired: %0d of %0d", n_err, n_retired, N_INSTR);
        if (n_err == 0 && n_retired == N_INSTR) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/mips_isa_pkg.sv
src/mips_pipe_pkg.sv
src/pipe_reg.sv
src/reg_file.sv
src/alu_ctl_dec.sv
src/decode.sv
src/execute.sv
src/mips_core.sv
tb/mips_core_assert.sv
tb/mips_core_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mips_core_tb
FILELIST = src.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
